//--- verilog/controlUnitPkg.sv
package controlUnitPkg;

    // Phases of the multicycle control FSM
    typedef enum logic [2:0] {
        phaseReset     = 3'd0,
        phaseFetch     = 3'd1,
        phaseDecode    = 3'd2,
        phaseExecAdd   = 3'd3,
        phaseExecAddiu = 3'd4,
        phaseOverflow  = 3'd5,
        phaseBadOpcode = 3'd6
    } phaseT;

    // Cycle index within a phase
    typedef logic [1:0] stepT;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // Memory address select
    typedef enum logic [2:0] {
        iorPc = 3'd0
    } iorSelT;

    typedef enum logic [1:0] {
        regDstRt = 2'd0,
        regDstRd = 2'd1
    } regDstT;

    typedef enum logic [2:0] {
        memToRegNone   = 3'd0,
        memToRegAluOut = 3'd3
    } memToRegT;

    typedef enum logic [1:0] {
        srcAPc  = 2'd0,
        srcAReg = 2'd2
    } aluSrcAT;

    typedef enum logic [2:0] {
        srcBReg  = 3'd0,
        srcBFour = 3'd1,
        srcBImm  = 3'd2
    } aluSrcBT;

    typedef enum logic [2:0] {
        aluOpNone = 3'd0,
        aluOpAdd  = 3'd1
    } aluOpT;

    typedef enum logic [2:0] {
        pcSrcHold      = 3'd0,
        pcSrcAluResult = 3'd2
    } pcSourceT;

    // Everything the datapath sees in one cycle
    typedef struct packed {
        iorSelT   iorD;
        logic     memWr;
        logic     irWrite;
        regDstT   regDst;
        memToRegT memToReg;
        logic     regWr;
        logic     writeA;
        logic     writeB;
        aluSrcAT  aluSrcA;
        aluSrcBT  aluSrcB;
        aluOpT    aluOp;
        logic     aluOutWrite;
        pcSourceT pcSource;
        logic     pcWrite;
    } controlWordT;

    localparam opcodeT opcodeRType = 6'd0;
    localparam opcodeT opcodeAddiu = 6'd9;
    localparam functT  functAdd    = 6'd32;

    localparam stepT fetchLastStep  = 2'd3;
    localparam stepT decodeLastStep = 2'd1;
    localparam stepT execLastStep   = 2'd2;

    localparam controlWordT controlIdle = controlWordT'('0);

    // Single-cycle phases report step 0
    function automatic stepT phaseLastStep(input phaseT phase);
        stepT last;
        case (phase)
            phaseFetch:     last = fetchLastStep;
            phaseDecode:    last = decodeLastStep;
            phaseExecAdd:   last = execLastStep;
            phaseExecAddiu: last = execLastStep;
            default:        last = 2'd0;
        endcase
        return last;
    endfunction

endpackage

//--- verilog/phaseSequencer.sv
`timescale 1ns/1ns

module phaseSequencer
    import controlUnitPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  opcodeT opCode,
    input  functT  funct,
    input  logic   overflow,
    output phaseT  nextPhase,
    output stepT   nextStep,
    output logic   overflowSeen
);

    phaseT phase;
    stepT  step;
    phaseT decodedPhase;
    logic  atLastStep;

    assign atLastStep = (step == phaseLastStep(phase));

    // Only ADD and ADDIU decode to an execute phase
    always_comb begin
        if (opCode == opcodeRType && funct == functAdd) begin
            decodedPhase = phaseExecAdd;
        end else if (opCode == opcodeAddiu) begin
            decodedPhase = phaseExecAddiu;
        end else begin
            decodedPhase = phaseBadOpcode;
        end
    end

    always_comb begin
        nextPhase    = phase;
        nextStep     = step + 2'd1;
        overflowSeen = 1'b0;

        case (phase)
            phaseReset: begin
                nextPhase = phaseFetch;
                nextStep  = 2'd0;
            end

            phaseFetch: begin
                if (atLastStep) begin
                    nextPhase = phaseDecode;
                    nextStep  = 2'd0;
                end
            end

            phaseDecode: begin
                if (atLastStep) begin
                    nextPhase = decodedPhase;
                    nextStep  = 2'd0;
                end
            end

            phaseExecAdd: begin
                // Overflow matters on the two write-back steps
                if (!atLastStep && overflow) begin
                    overflowSeen = 1'b1;
                    nextPhase    = phaseOverflow;
                    nextStep     = 2'd0;
                end else if (atLastStep) begin
                    nextPhase = phaseFetch;
                    nextStep  = 2'd0;
                end
            end

            phaseExecAddiu: begin
                if (atLastStep) begin
                    nextPhase = phaseFetch;
                    nextStep  = 2'd0;
                end
            end

            // Exception phases park here
            default: begin
                nextPhase = phase;
                nextStep  = 2'd0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= phaseReset;
            step  <= 2'd0;
        end else begin
            phase <= nextPhase;
            step  <= nextStep;
        end
    end

    stepInRange: assert property (
        @(posedge clk) disable iff (reset)
        step <= phaseLastStep(phase)
    ) else $error("step %0d beyond last step of phase %s", step, phase.name());

    // Only reset leaves an exception
    exceptionParked: assert property (
        @(posedge clk)
        ((phase == phaseOverflow || phase == phaseBadOpcode) && !reset)
            |=> (phase == $past(phase))
    ) else $error("exception phase left without reset");

endmodule

//--- verilog/controlWordRegister.sv
`timescale 1ns/1ns

module controlWordRegister
    import controlUnitPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  phaseT       nextPhase,
    input  stepT        nextStep,
    input  logic        overflowSeen,
    output controlWordT word,
    output logic        resetOut
);

    controlWordT wordNext;

    always_comb begin
        wordNext = controlIdle;

        case (nextPhase)
            phaseFetch: begin
                if (nextStep == fetchLastStep) begin
                    // Instruction and PC load together
                    wordNext.irWrite = 1'b1;
                    wordNext.pcWrite = 1'b1;
                end else begin
                    wordNext.iorD     = iorPc;
                    wordNext.aluSrcA  = srcAPc;
                    wordNext.aluSrcB  = srcBFour;
                    wordNext.aluOp    = aluOpAdd;
                    wordNext.pcSource = pcSrcAluResult;
                end
            end

            phaseDecode: begin
                // Register read and branch target precompute
                wordNext.writeA      = 1'b1;
                wordNext.writeB      = 1'b1;
                wordNext.aluOutWrite = 1'b1;
                wordNext.aluSrcA     = srcAPc;
                wordNext.aluSrcB     = srcBReg;
                wordNext.aluOp       = aluOpAdd;
            end

            phaseExecAdd: begin
                if (nextStep == 2'd0) begin
                    wordNext.aluSrcA     = srcAReg;
                    wordNext.aluSrcB     = srcBReg;
                    wordNext.aluOp       = aluOpAdd;
                    wordNext.aluOutWrite = 1'b1;
                end else begin
                    wordNext.regWr    = 1'b1;
                    wordNext.regDst   = regDstRd;
                    wordNext.memToReg = memToRegAluOut;
                end
            end

            phaseExecAddiu: begin
                if (nextStep == 2'd0) begin
                    wordNext.aluSrcA     = srcAReg;
                    wordNext.aluSrcB     = srcBImm;
                    wordNext.aluOp       = aluOpAdd;
                    wordNext.aluOutWrite = 1'b1;
                end else begin
                    wordNext.regWr    = 1'b1;
                    wordNext.regDst   = regDstRt;
                    wordNext.memToReg = memToRegAluOut;
                end
            end

            default: begin
                wordNext = controlIdle;
            end
        endcase

        // No write-back once the ADD result overflowed
        if (overflowSeen) begin
            wordNext = controlIdle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            word     <= controlIdle;
            resetOut <= 1'b1;
        end else begin
            word     <= wordNext;
            resetOut <= 1'b0;
        end
    end

    irWriteWithPcWrite: assert property (
        @(posedge clk) disable iff (reset)
        word.irWrite |-> word.pcWrite
    ) else $error("irWrite without pcWrite");

    // Fetch and write-back never share a cycle
    noRegWrOnFetch: assert property (
        @(posedge clk) disable iff (reset)
        !(word.regWr && word.irWrite)
    ) else $error("regWr together with irWrite");

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/1ns

module controlUnit
    import controlUnitPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  opcodeT   opCode,
    input  functT    funct,
    input  logic     overflow,
    output iorSelT   iorD,
    output logic     memWr,
    output logic     irWrite,
    output regDstT   regDst,
    output memToRegT memToReg,
    output logic     regWr,
    output logic     writeA,
    output logic     writeB,
    output aluSrcAT  aluSrcA,
    output aluSrcBT  aluSrcB,
    output aluOpT    aluOp,
    output logic     aluOutWrite,
    output pcSourceT pcSource,
    output logic     pcWrite,
    output logic     resetOut
);

    phaseT       nextPhase;
    stepT        nextStep;
    logic        overflowSeen;
    controlWordT word;

    phaseSequencer u_phaseSequencer (
        .clk          (clk),
        .reset        (reset),
        .opCode       (opCode),
        .funct        (funct),
        .overflow     (overflow),
        .nextPhase    (nextPhase),
        .nextStep     (nextStep),
        .overflowSeen (overflowSeen)
    );

    controlWordRegister u_controlWordRegister (
        .clk          (clk),
        .reset        (reset),
        .nextPhase    (nextPhase),
        .nextStep     (nextStep),
        .overflowSeen (overflowSeen),
        .word         (word),
        .resetOut     (resetOut)
    );

    // Control word out to the datapath
    assign iorD        = word.iorD;
    assign memWr       = word.memWr;
    assign irWrite     = word.irWrite;
    assign regDst      = word.regDst;
    assign memToReg    = word.memToReg;
    assign regWr       = word.regWr;
    assign writeA      = word.writeA;
    assign writeB      = word.writeB;
    assign aluSrcA     = word.aluSrcA;
    assign aluSrcB     = word.aluSrcB;
    assign aluOp       = word.aluOp;
    assign aluOutWrite = word.aluOutWrite;
    assign pcSource    = word.pcSource;
    assign pcWrite     = word.pcWrite;

endmodule

//--- verification/controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb
    import controlUnitPkg::*;
();

    localparam int rowCount = 10;
    localparam int watchdogCycles = 2000;
    localparam int irWriteTimeout = 8;

    localparam logic [1:0] ovfNone  = 2'd0;
    localparam logic [1:0] ovfStep1 = 2'd1;
    localparam logic [1:0] ovfStep2 = 2'd2;

    localparam logic [1:0] outComplete = 2'd0;
    localparam logic [1:0] outOverflow = 2'd1;
    localparam logic [1:0] outBadOp    = 2'd2;

    localparam int kindAdd   = 0;
    localparam int kindAddiu = 1;
    localparam int kindBad   = 2;

    typedef struct packed {
        opcodeT     op;
        functT      fn;
        logic [1:0] ovf;
        logic [1:0] outcome;
    } rowT;

    logic     clk;
    logic     reset;
    opcodeT   opCode;
    functT    funct;
    logic     overflow;
    iorSelT   iorD;
    logic     memWr;
    logic     irWrite;
    regDstT   regDst;
    memToRegT memToReg;
    logic     regWr;
    logic     writeA;
    logic     writeB;
    aluSrcAT  aluSrcA;
    aluSrcBT  aluSrcB;
    aluOpT    aluOp;
    logic     aluOutWrite;
    pcSourceT pcSource;
    logic     pcWrite;
    logic     resetOut;

    rowT         rows [rowCount];
    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;

    controlUnit u_dut (
        .clk         (clk),
        .reset       (reset),
        .opCode      (opCode),
        .funct       (funct),
        .overflow    (overflow),
        .iorD        (iorD),
        .memWr       (memWr),
        .irWrite     (irWrite),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .regWr       (regWr),
        .writeA      (writeA),
        .writeB      (writeB),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .aluOutWrite (aluOutWrite),
        .pcSource    (pcSource),
        .pcWrite     (pcWrite),
        .resetOut    (resetOut)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [5:0] randomField();
        logic [5:0] v;
        v = '0;
        for (int i = 0; i < 6; i++) begin
            v = {v[4:0], lfsrState[0]};
            if (lfsrState[0]) begin
                lfsrState = (lfsrState >> 1) ^ 32'h8020_0003;
            end else begin
                lfsrState = lfsrState >> 1;
            end
        end
        return v;
    endfunction

    function automatic int decodeKind(input opcodeT op, input functT fn);
        int kind;
        if (op == opcodeRType && fn == functAdd) begin
            kind = kindAdd;
        end else if (op == opcodeAddiu) begin
            kind = kindAddiu;
        end else begin
            kind = kindBad;
        end
        return kind;
    endfunction

    // Expected word per edge after reset release
    // Edge 10 restarts fetch
    function automatic controlWordT expectedWord(input int edgeNum, input int kind,
                                                 input int parkEdge);
        controlWordT w;
        int e;
        w = controlIdle;
        e = (edgeNum >= 10) ? edgeNum - 9 : edgeNum;
        if (parkEdge == 0 || edgeNum < parkEdge) begin
            case (e)
                1, 2, 3: begin
                    w.iorD     = iorPc;
                    w.aluSrcA  = srcAPc;
                    w.aluSrcB  = srcBFour;
                    w.aluOp    = aluOpAdd;
                    w.pcSource = pcSrcAluResult;
                end
                4: begin
                    w.irWrite = 1'b1;
                    w.pcWrite = 1'b1;
                end
                5, 6: begin
                    w.writeA      = 1'b1;
                    w.writeB      = 1'b1;
                    w.aluOutWrite = 1'b1;
                    w.aluSrcA     = srcAPc;
                    w.aluSrcB     = srcBReg;
                    w.aluOp       = aluOpAdd;
                end
                7: begin
                    if (kind != kindBad) begin
                        w.aluSrcA     = srcAReg;
                        w.aluOp       = aluOpAdd;
                        w.aluOutWrite = 1'b1;
                        if (kind == kindAdd) begin
                            w.aluSrcB = srcBReg;
                        end else begin
                            w.aluSrcB = srcBImm;
                        end
                    end
                end
                8, 9: begin
                    if (kind != kindBad) begin
                        w.regWr    = 1'b1;
                        w.memToReg = memToRegAluOut;
                        if (kind == kindAdd) begin
                            w.regDst = regDstRd;
                        end else begin
                            w.regDst = regDstRt;
                        end
                    end
                end
                default: begin
                    w = controlIdle;
                end
            endcase
        end
        return w;
    endfunction

    function automatic controlWordT readWord();
        controlWordT got;
        got.iorD        = iorD;
        got.memWr       = memWr;
        got.irWrite     = irWrite;
        got.regDst      = regDst;
        got.memToReg    = memToReg;
        got.regWr       = regWr;
        got.writeA      = writeA;
        got.writeB      = writeB;
        got.aluSrcA     = aluSrcA;
        got.aluSrcB     = aluSrcB;
        got.aluOp       = aluOp;
        got.aluOutWrite = aluOutWrite;
        got.pcSource    = pcSource;
        got.pcWrite     = pcWrite;
        return got;
    endfunction

    task automatic checkWord(input controlWordT exp, input string where);
        controlWordT got;
        got = readWord();
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %0t ns: %s control word %h, expected %h", $time, where, got, exp);
        end
    endtask

    task automatic checkResetOut(input logic exp, input string where);
        checkCount++;
        if (resetOut !== exp) begin
            errorCount++;
            $display("[FAIL] %0t ns: %s resetOut %b, expected %b", $time, where, resetOut, exp);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        reset    <= 1'b1;
        overflow <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 15) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            checkWord(controlIdle, $sformatf("reset cycle %0d", i));
            checkResetOut(1'b1, $sformatf("reset cycle %0d", i));
        end
    endtask

    task automatic runRow(input int r);
        int kind;
        int parkEdge;
        int lastEdge;
        int ovfStep;
        int firstIr;
        int secondIr;
        string where;
        applyReset();
        kind     = decodeKind(rows[r].op, rows[r].fn);
        ovfStep  = int'(rows[r].ovf);
        parkEdge = 0;
        if (rows[r].outcome == outBadOp) begin
            parkEdge = 7;
        end else if (rows[r].outcome == outOverflow) begin
            parkEdge = 7 + ovfStep;
        end
        lastEdge = (parkEdge == 0) ? 13 : parkEdge + 20;
        firstIr  = 0;
        secondIr = 0;
        for (int edgeNum = 1; edgeNum <= lastEdge; edgeNum++) begin
            @(posedge clk);
            // Instruction fields follow the irWrite handshake
            if (firstIr != 0 && edgeNum == firstIr + 1) begin
                opCode <= rows[r].op;
                funct  <= rows[r].fn;
            end
            if (ovfStep != 0 && edgeNum == 6 + ovfStep) begin
                overflow <= 1'b1;
            end
            @(negedge clk);
            where = $sformatf("row %0d edge %0d", r, edgeNum);
            checkWord(expectedWord(edgeNum, kind, parkEdge), where);
            checkResetOut(1'b0, where);
            if (irWrite === 1'b1) begin
                if (firstIr == 0) begin
                    firstIr = edgeNum;
                end else if (secondIr == 0) begin
                    secondIr = edgeNum;
                end
            end
            if (firstIr == 0 && edgeNum == irWriteTimeout) begin
                errorCount++;
                $display("Row %0d: no irWrite within %0d edges after reset", r, irWriteTimeout);
            end
        end
        if (parkEdge == 0 && secondIr - firstIr != 9) begin
            errorCount++;
            $display("[FAIL] %0t ns: row %0d irWrite spacing %0d, expected 9",
                     $time, r, secondIr - firstIr);
        end else if (parkEdge != 0 && secondIr != 0) begin
            errorCount++;
            $display("[FAIL] %0t ns: row %0d irWrite at edge %0d while parked", $time, r, secondIr);
        end
    endtask

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Simulation did not finish within %0d cycles", watchdogCycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        opCode     = '0;
        funct      = '0;
        overflow   = 1'b0;
        errorCount = 0;
        checkCount = 0;
        lfsrState  = 32'hdc56;

        rows[0] = '{opcodeRType, functAdd, ovfNone, outComplete};
        rows[1] = '{opcodeAddiu, 6'd5, ovfNone, outComplete};
        rows[2] = '{opcodeAddiu, 6'd0, ovfStep1, outComplete};
        rows[3] = '{opcodeRType, functAdd, ovfStep1, outOverflow};
        rows[4] = '{opcodeRType, functAdd, ovfStep2, outOverflow};
        // AND, LW and SUB are unknown here
        rows[5] = '{opcodeRType, 6'd36, ovfNone, outBadOp};
        rows[6] = '{6'd35, 6'd0, ovfNone, outBadOp};
        rows[7] = '{opcodeRType, 6'd34, ovfStep1, outBadOp};
        for (int r = 8; r < rowCount; r++) begin
            rows[r].op      = randomField();
            rows[r].fn      = randomField();
            rows[r].ovf     = ovfNone;
            rows[r].outcome = outBadOp;
            if (rows[r].op == opcodeAddiu) begin
                rows[r].op = rows[r].op ^ 6'h10;
            end
            if (rows[r].op == opcodeRType && rows[r].fn == functAdd) begin
                rows[r].fn = rows[r].fn ^ 6'h01;
            end
        end

        for (int r = 0; r < rowCount; r++) begin
            runRow(r);
        end

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
verilog/controlUnitPkg.sv
verilog/phaseSequencer.sv
verilog/controlWordRegister.sv
verilog/controlUnit.sv
verification/controlUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module controlUnitTb \
    -Mdir "$buildDir" \
    -o controlUnitTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/controlUnitTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TESTS FAILED" "$logFile"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$logFile"; then
    echo "No result found in $logFile"
    exit 1
fi
exit 0
